// ==== bench/datapathBench.sv ====
// testbench for the register and bus datapath
//   clock, reset and one task per cycle of strobes
//   LFSR operands and reference arithmetic for binary and decimal mode
//   concurrent checks of dataOut and status at the falling edge
`timescale 1ns/10ps
`default_nettype none

module datapathBench import datapathPkg::*; import statusPkg::*; ();

    typedef enum int {opSum, opAnd, opEor, opOr, opShr} aluOp;

    logic       phi2;
    logic       rstAll;
    logic [7:0] extDataIn;
    logic       dlToBus, addToBus, acToBus, xToBus, yToBus, spToBus, pToBus;
    logic       busToAc, busToX, busToY, busToSp, busToP, busToOut;
    logic       sumSel, andSel, eorSel, orSel, srSel, carryIn, dlToAlu, dlInvToAlu;
    logic       decAddAdjust, decSubAdjust, flagsAluNzcv, flagsAluNz, loadNzFromBus;
    logic       setC, clrC, setI, clrI, clrV, setD, clrD;
    logic [7:0] dataOut;
    logic [7:0] status;

    // check requests armed for one cycle at a time
    logic       checkOut;
    logic       checkStatus;
    logic [7:0] expOut;
    logic [7:0] expStatus;

    // reference model of the visible registers
    logic [7:0]  modelAc, modelX, modelY, modelSp, lastIn;
    statusWord   modelP;
    logic [15:0] lfsrState;
    busSource    regOrder [4] = '{srcX, srcY, srcStack, srcAccum};

    datapathTop i_dut (.*);

    initial phi2 = 1'b0;
    always #4 phi2 = ~phi2;

    outMatch: assert property (@(negedge phi2) disable iff (rstAll)
        checkOut |-> dataOut == expOut)
        else begin
            $display("FAIL dataOut got %h expected %h", dataOut, expOut);
            failRun();
        end

    statusMatch: assert property (@(negedge phi2) disable iff (rstAll)
        checkStatus |-> status == expStatus)
        else begin
            $display("FAIL status got %h expected %h", status, expStatus);
            failRun();
        end

    task automatic failRun();
        $display("Checks failed");
        $fatal(1);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic drawBit();
        lfsrState = {lfsrState[14:0],
                     lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
        return lfsrState[0];
    endfunction

    function automatic logic [7:0] drawBits(input int n);
        logic [7:0] val;
        val = 8'h00;
        for (int b = 0; b < n; b++) begin
            val = {val[6:0], drawBit()};
        end
        return val;
    endfunction

    function automatic logic [7:0] randomBcd();
        logic [7:0] r;
        r = drawBits(8);
        return {r[7:4] % 4'd10, r[3:0] % 4'd10};
    endfunction

    function automatic int bcdValue(input logic [7:0] v);
        return int'(v[7:4]) * 10 + int'(v[3:0]);
    endfunction

    function automatic logic [7:0] toBcd(input int n);
        return {4'(n / 10), 4'(n % 10)};
    endfunction

    function automatic logic [7:0] slotValue(input busSource s);
        case (s)
            srcDataLatch: return lastIn;
            // the hold register saw no select in the cycle before
            srcAdderHold: return 8'h00;
            srcAccum:     return modelAc;
            srcX:         return modelX;
            srcY:         return modelY;
            srcStack:     return modelSp;
            default:      return modelP.byteVal;
        endcase
    endfunction

    task automatic clearStrobes();
        {dlToBus, addToBus, acToBus, xToBus, yToBus, spToBus, pToBus} <= '0;
        {busToAc, busToX, busToY, busToSp, busToP, busToOut} <= '0;
        {sumSel, andSel, eorSel, orSel, srSel, carryIn, dlToAlu, dlInvToAlu} <= '0;
        {decAddAdjust, decSubAdjust, flagsAluNzcv, flagsAluNz, loadNzFromBus} <= '0;
        {setC, clrC, setI, clrI, clrV, setD, clrD} <= '0;
        checkOut <= 1'b0;
        checkStatus <= 1'b0;
    endtask

    task automatic setDrive(input busSource s);
        case (s)
            srcDataLatch: dlToBus <= 1'b1;
            srcAdderHold: addToBus <= 1'b1;
            srcAccum:     acToBus <= 1'b1;
            srcX:         xToBus <= 1'b1;
            srcY:         yToBus <= 1'b1;
            srcStack:     spToBus <= 1'b1;
            default:      pToBus <= 1'b1;
        endcase
    endtask

    task automatic setLoad(input busSource s);
        case (s)
            srcAccum: busToAc <= 1'b1;
            srcX:     busToX <= 1'b1;
            srcY:     busToY <= 1'b1;
            srcStack: busToSp <= 1'b1;
            default:  busToP <= 1'b1;
        endcase
    endtask

    task automatic presentCycle(input logic [7:0] v);
        @(posedge phi2);
        clearStrobes();
        extDataIn <= v;
        lastIn = v;
    endtask

    task automatic transferCycle(input busSource from, input busSource to);
        @(posedge phi2);
        clearStrobes();
        setDrive(from);
        setLoad(to);
    endtask

    task automatic outCycle(input busSource from);
        @(posedge phi2);
        clearStrobes();
        setDrive(from);
        busToOut <= 1'b1;
    endtask

    task automatic pairOutCycle(input busSource first, input busSource second);
        @(posedge phi2);
        clearStrobes();
        setDrive(second);
        setDrive(first);
        busToOut <= 1'b1;
    endtask

    task automatic floatOutCycle();
        @(posedge phi2);
        clearStrobes();
        busToOut <= 1'b1;
    endtask

    task automatic aluCycle(input aluOp op, input logic cin, input logic inv);
        @(posedge phi2);
        clearStrobes();
        acToBus <= 1'b1;
        carryIn <= cin;
        if (inv) begin
            dlInvToAlu <= 1'b1;
        end else begin
            dlToAlu <= 1'b1;
        end
        case (op)
            opSum:   sumSel <= 1'b1;
            opAnd:   andSel <= 1'b1;
            opEor:   eorSel <= 1'b1;
            opOr:    orSel <= 1'b1;
            default: srSel <= 1'b1;
        endcase
    endtask

    task automatic resultCycle(input logic nzcv, input logic nz, input logic dAdd,
                               input logic dSub);
        @(posedge phi2);
        clearStrobes();
        addToBus <= 1'b1;
        busToAc <= 1'b1;
        flagsAluNzcv <= nzcv;
        flagsAluNz <= nz;
        decAddAdjust <= dAdd;
        decSubAdjust <= dSub;
    endtask

    task automatic checkCycle(input logic wantOut, input logic [7:0] v);
        @(posedge phi2);
        clearStrobes();
        checkOut <= wantOut;
        expOut <= v;
        checkStatus <= 1'b1;
        expStatus <= modelP.byteVal;
    endtask

    task automatic loadReg(input busSource dest, input logic [7:0] v);
        presentCycle(v);
        transferCycle(srcDataLatch, dest);
        case (dest)
            srcAccum: modelAc = v;
            srcX:     modelX = v;
            srcY:     modelY = v;
            srcStack: modelSp = v;
            default: begin
                modelP.byteVal = v;
                modelP.flags.one = 1'b1;
                modelP.flags.brk = 1'b0;
            end
        endcase
    endtask

    task automatic readBack(input busSource src);
        outCycle(src);
        checkCycle(1'b1, slotValue(src));
    endtask

    task automatic runAlu(input aluOp op, input logic [7:0] b, input logic cin,
                          input logic inv);
        logic [7:0] bEff;
        logic [8:0] wide;
        logic [7:0] res;
        logic       useNzcv;
        int         signedSum;
        bEff = inv ? ~b : b;
        wide = {1'b0, modelAc} + {1'b0, bEff} + {8'h00, cin};
        signedSum = int'($signed(modelAc)) + int'($signed(bEff)) + int'(cin);
        useNzcv = (op == opSum) || (op == opShr);
        case (op)
            opSum:   res = wide[7:0];
            opAnd:   res = modelAc & bEff;
            opEor:   res = modelAc ^ bEff;
            opOr:    res = modelAc | bEff;
            default: res = {cin, bEff[7:1]};
        endcase
        if (op == opSum) begin
            modelP.flags.c = wide[8];
            // signed result outside the 8-bit range
            modelP.flags.v = (signedSum > 127) || (signedSum < -128);
        end else if (op == opShr) begin
            modelP.flags.c = bEff[0];
            modelP.flags.v = 1'b0;
        end
        modelP.flags.n = res[7];
        modelP.flags.z = (res == 8'h00);
        presentCycle(b);
        aluCycle(op, cin, inv);
        resultCycle(useNzcv, ~useNzcv, 1'b0, 1'b0);
        modelAc = res;
        readBack(srcAccum);
    endtask

    // no flag strobe here so status keeps its value
    task automatic runDecimal(input logic sub, input logic [7:0] a, input logic [7:0] b,
                              input logic cin);
        int total;
        loadReg(srcAccum, a);
        presentCycle(b);
        aluCycle(opSum, sub ? 1'b1 : cin, sub);
        resultCycle(1'b0, 1'b0, ~sub, sub);
        if (sub) begin
            total = (bcdValue(a) - bcdValue(b) + 100) % 100;
        end else begin
            total = (bcdValue(a) + bcdValue(b) + int'(cin)) % 100;
        end
        modelAc = toBcd(total);
        readBack(srcAccum);
    endtask

    // strobe order is setC, clrC, setI, clrI, clrV, setD, clrD
    task automatic flagStep(input logic [6:0] st);
        @(posedge phi2);
        clearStrobes();
        {setC, clrC, setI, clrI, clrV, setD, clrD} <= st;
        if (st[6]) begin
            modelP.flags.c = 1'b1;
        end else if (st[5]) begin
            modelP.flags.c = 1'b0;
        end
        if (st[4]) begin
            modelP.flags.i = 1'b1;
        end else if (st[3]) begin
            modelP.flags.i = 1'b0;
        end
        if (st[2]) begin
            modelP.flags.v = 1'b0;
        end
        if (st[1]) begin
            modelP.flags.d = 1'b1;
        end else if (st[0]) begin
            modelP.flags.d = 1'b0;
        end
        checkCycle(1'b0, 8'h00);
    endtask

    // N and Z taken straight from the latch byte on the bus
    task automatic loadNzStep(input logic [7:0] v);
        presentCycle(v);
        @(posedge phi2);
        clearStrobes();
        dlToBus <= 1'b1;
        loadNzFromBus <= 1'b1;
        modelP.flags.n = v[7];
        modelP.flags.z = (v == 8'h00);
        checkCycle(1'b0, 8'h00);
    endtask

    task automatic waitResetState();
        int cycles;
        cycles = 0;
        while ($isunknown(status) || $isunknown(dataOut)) begin
            if (cycles == 10) begin
                $display("timeout: status and dataOut stayed unknown after reset");
                failRun();
            end
            @(negedge phi2);
            cycles++;
        end
    endtask

    initial begin
        logic [7:0] r;
        logic [7:0] opA;
        logic [7:0] opB;
        rstAll <= 1'b1;
        extDataIn <= 8'h00;
        clearStrobes();
        lfsrState = 16'd39;
        lastIn = 8'h00;
        {modelAc, modelX, modelY, modelSp} = '0;
        modelP.byteVal = 8'h20;
        repeat (3) @(posedge phi2);
        rstAll <= 1'b0;
        @(negedge phi2);
        waitResetState();
        checkCycle(1'b1, 8'h00);

        // transfers through the latch and back out
        for (int k = 0; k < 4; k++) begin
            loadReg(regOrder[k], drawBits(8));
            readBack(regOrder[k]);
        end
        for (int k = 0; k < 4; k++) begin
            readBack(regOrder[k]);
        end

        // binary add, then subtract through the inverted latch
        repeat (12) begin
            loadReg(srcAccum, drawBits(8));
            runAlu(opSum, drawBits(8), drawBit(), 1'b0);
        end
        repeat (12) begin
            loadReg(srcAccum, drawBits(8));
            runAlu(opSum, drawBits(8), 1'b1, 1'b1);
        end

        for (int o = 1; o < 5; o++) begin
            repeat (8) begin
                runAlu(aluOp'(o), drawBits(8), drawBit(), 1'b0);
            end
        end

        repeat (12) begin
            opA = randomBcd();
            opB = randomBcd();
            runDecimal(1'b0, opA, opB, drawBit());
        end
        repeat (12) begin
            opA = randomBcd();
            opB = randomBcd();
            runDecimal(1'b1, opA, opB, 1'b0);
        end

        flagStep(7'b1111111);
        repeat (16) begin
            r = drawBits(7);
            flagStep(r[6:0]);
        end
        loadNzStep(8'h00);
        repeat (4) begin
            loadNzStep(drawBits(8));
        end
        repeat (4) begin
            loadReg(srcStatus, drawBits(8));
            readBack(srcStatus);
        end

        // arbitration, idle precharge first
        floatOutCycle();
        checkCycle(1'b1, 8'hFF);
        for (int s1 = 0; s1 < busSourceCount - 1; s1++) begin
            for (int s2 = s1 + 1; s2 < busSourceCount; s2++) begin
                pairOutCycle(busSource'(s1), busSource'(s2));
                checkCycle(1'b1, slotValue(busSource'(s1)));
            end
        end

        @(posedge phi2);
        clearStrobes();
        @(negedge phi2);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/accumulator.sv ====
// accumulator
//   decimal add and subtract adjust of the incoming bus value
//   AC register, loaded from the adjuster, offered back to the bus
`timescale 1ns/10ps
`default_nettype none

module accumulator import datapathPkg::*; (
    input  logic    phi2,
    input  logic    rstAll,
    input  dataWord busValue,
    input  logic    busToAc,
    input  logic    acToBus,
    input  logic    decAddAdjust,
    input  logic    decSubAdjust,
    aluResultIf.consumer result,
    output logic    acReq,
    output dataWord acData
);

    dataWord adjusted;
    dataWord acValue;

    // flags come from the hold register, so they belong to the value on the bus
    always_comb begin
        adjusted = busValue;
        if (decAddAdjust) begin
            if (busValue[3:0] > 4'd9 || result.halfCarry) begin
                adjusted = adjusted + 8'h06;
            end
            if (result.carry || busValue > 8'h99) begin
                adjusted = adjusted + 8'h60;
            end
        end else if (decSubAdjust) begin
            // a borrow shows up as a clear carry
            if (!result.halfCarry) begin
                adjusted = adjusted - 8'h06;
            end
            if (!result.carry) begin
                adjusted = adjusted - 8'h60;
            end
        end
    end

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            acValue <= '0;
        end else if (busToAc) begin
            acValue <= adjusted;
        end
    end

    assign acReq  = acToBus;
    assign acData = acValue;

endmodule

`default_nettype wire

// ==== rtl/aluCore.sv ====
// ALU and adder hold register
//   B input select from the data latch, true or inverted
//   add with carry in, AND, EOR, OR, shift right
//   hold register for the result and its flags
`timescale 1ns/10ps
`default_nettype none

module aluCore import datapathPkg::*; (
    input  logic    phi2,
    input  logic    rstAll,
    input  dataWord busValue,
    input  dataWord dlValue,
    input  logic    sumSel,
    input  logic    andSel,
    input  logic    eorSel,
    input  logic    orSel,
    input  logic    srSel,
    input  logic    carryIn,
    input  logic    dlToAlu,
    input  logic    dlInvToAlu,
    input  logic    addToBus,
    output logic    addReq,
    output dataWord addData,
    aluResultIf.producer result
);

    dataWord    bOperand;
    logic [4:0] lowSum;
    logic [4:0] highSum;
    dataWord    sumValue;
    dataWord    aluValue;
    logic       aluCarry;
    logic       aluOverflow;
    logic       aluHalfCarry;
    dataWord    holdValue;
    logic       holdCarry;
    logic       holdOverflow;
    logic       holdHalfCarry;

    assign bOperand = dlInvToAlu ? ~dlValue : (dlToAlu ? dlValue : '0);

    // two nibble steps so the half carry falls out of the low one
    assign lowSum   = {1'b0, busValue[3:0]} + {1'b0, bOperand[3:0]} + {4'b0, carryIn};
    assign highSum  = {1'b0, busValue[7:4]} + {1'b0, bOperand[7:4]} + {4'b0, lowSum[4]};
    assign sumValue = {highSum[3:0], lowSum[3:0]};

    always_comb begin
        aluValue     = '0;
        aluCarry     = 1'b0;
        aluOverflow  = 1'b0;
        aluHalfCarry = 1'b0;
        if (sumSel) begin
            aluValue     = sumValue;
            aluCarry     = highSum[4];
            aluHalfCarry = lowSum[4];
            // same operand signs but the sum flipped sign
            aluOverflow  = (busValue[7] == bOperand[7]) && (sumValue[7] != busValue[7]);
        end else if (andSel) begin
            aluValue = busValue & bOperand;
        end else if (eorSel) begin
            aluValue = busValue ^ bOperand;
        end else if (orSel) begin
            aluValue = busValue | bOperand;
        end else if (srSel) begin
            aluValue = {carryIn, bOperand[7:1]};
            aluCarry = bOperand[0];
        end
    end

    // captures every edge so a new operation can overlap the bus read
    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            holdValue     <= '0;
            holdCarry     <= 1'b0;
            holdOverflow  <= 1'b0;
            holdHalfCarry <= 1'b0;
        end else begin
            holdValue     <= aluValue;
            holdCarry     <= aluCarry;
            holdOverflow  <= aluOverflow;
            holdHalfCarry <= aluHalfCarry;
        end
    end

    assign result.holdValue = holdValue;
    assign result.carry     = holdCarry;
    assign result.overflow  = holdOverflow;
    assign result.halfCarry = holdHalfCarry;

    assign addReq  = addToBus;
    assign addData = holdValue;

endmodule

`default_nettype wire

// ==== rtl/aluResultIf.sv ====
// adder hold register result bundle
//   held ALU value with carry, overflow and half carry
//   producer side for the ALU, consumer side for AC and P
`timescale 1ns/10ps
`default_nettype none

interface aluResultIf import datapathPkg::*; ();

    dataWord holdValue;
    logic    carry;
    logic    overflow;
    logic    halfCarry;

    modport producer (
        output holdValue,
        output carry,
        output overflow,
        output halfCarry
    );

    modport consumer (
        input holdValue,
        input carry,
        input overflow,
        input halfCarry
    );

endinterface

`default_nettype wire

// ==== rtl/busArbiter.sv ====
// internal bus arbiter
//   fixed priority pick of one driver per cycle
//   idle precharge value when no source requests
`timescale 1ns/10ps
`default_nettype none

module busArbiter import datapathPkg::*; (
    input  logic [busSourceCount-1:0] sourceReq,
    input  dataWord                   sourceData [busSourceCount],
    output dataWord                   busValue
);

    // walk from the lowest priority up so the lowest index lands last
    always_comb begin
        busValue = busIdleValue;
        for (int s = busSourceCount - 1; s >= 0; s--) begin
            if (sourceReq[s]) begin
                busValue = sourceData[s];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dataPort.sv ====
// external data port
//   input data latch, sampled every cycle
//   output data register, loaded from the bus
`timescale 1ns/10ps
`default_nettype none

module dataPort import datapathPkg::*; (
    input  logic    phi2,
    input  logic    rstAll,
    input  dataWord extDataIn,
    input  dataWord busValue,
    input  logic    dlToBus,
    input  logic    busToOut,
    output logic    dlReq,
    output dataWord dlValue,
    output dataWord dataOut
);

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            dlValue <= '0;
            dataOut <= '0;
        end else begin
            dlValue <= extDataIn;
            if (busToOut) begin
                dataOut <= busValue;
            end
        end
    end

    assign dlReq = dlToBus;

endmodule

`default_nettype wire

// ==== rtl/datapathPkg.sv ====
// datapath word definitions
//   word width and the data word type
//   bus source numbering, which is also the arbiter priority order
//   bus precharge value
`default_nettype none

package datapathPkg;

    localparam int wordWidth = 8;

    typedef logic [wordWidth-1:0] dataWord;

    // lower value wins the bus when several sources request it
    typedef enum logic [2:0] {
        srcDataLatch = 3'd0,
        srcAdderHold = 3'd1,
        srcAccum     = 3'd2,
        srcX         = 3'd3,
        srcY         = 3'd4,
        srcStack     = 3'd5,
        srcStatus    = 3'd6
    } busSource;

    localparam int busSourceCount = 7;

    // precharged bus reads all ones when nobody drives it
    localparam dataWord busIdleValue = 8'hFF;

endpackage

`default_nettype wire

// ==== rtl/datapathTop.sv ====
// register and bus datapath top level
//   data port, ALU with hold register, accumulator, X/Y/SP, status
//   bus arbiter joining all drivers onto the internal bus
`timescale 1ns/10ps
`default_nettype none

module datapathTop
    import datapathPkg::*;
    import statusPkg::*;
(
    input  logic       phi2,
    input  logic       rstAll,
    input  logic [7:0] extDataIn,
    input  logic       dlToBus,
    input  logic       addToBus,
    input  logic       acToBus,
    input  logic       xToBus,
    input  logic       yToBus,
    input  logic       spToBus,
    input  logic       pToBus,
    input  logic       busToAc,
    input  logic       busToX,
    input  logic       busToY,
    input  logic       busToSp,
    input  logic       busToP,
    input  logic       busToOut,
    input  logic       sumSel,
    input  logic       andSel,
    input  logic       eorSel,
    input  logic       orSel,
    input  logic       srSel,
    input  logic       carryIn,
    input  logic       dlToAlu,
    input  logic       dlInvToAlu,
    input  logic       decAddAdjust,
    input  logic       decSubAdjust,
    input  logic       flagsAluNzcv,
    input  logic       flagsAluNz,
    input  logic       loadNzFromBus,
    input  logic       setC,
    input  logic       clrC,
    input  logic       setI,
    input  logic       clrI,
    input  logic       clrV,
    input  logic       setD,
    input  logic       clrD,
    output logic [7:0] dataOut,
    output logic [7:0] status
);

    logic [busSourceCount-1:0] busReq;
    dataWord                   slotData [busSourceCount];
    dataWord                   busValue;
    dataWord                   dlValue;
    logic [2:0]                indexReq;
    dataWord                   xData;
    dataWord                   yData;
    dataWord                   spData;
    statusWord                 statusValue;

    aluResultIf aluResult ();

    dataPort u_dataPort (
        .phi2(phi2), .rstAll(rstAll), .extDataIn(extDataIn), .busValue(busValue),
        .dlToBus(dlToBus), .busToOut(busToOut), .dlReq(busReq[srcDataLatch]),
        .dlValue(dlValue), .dataOut(dataOut)
    );

    aluCore u_aluCore (
        .phi2(phi2), .rstAll(rstAll), .busValue(busValue), .dlValue(dlValue),
        .sumSel(sumSel), .andSel(andSel), .eorSel(eorSel), .orSel(orSel),
        .srSel(srSel), .carryIn(carryIn), .dlToAlu(dlToAlu), .dlInvToAlu(dlInvToAlu),
        .addToBus(addToBus), .addReq(busReq[srcAdderHold]),
        .addData(slotData[srcAdderHold]), .result(aluResult.producer)
    );

    accumulator u_accumulator (
        .phi2(phi2), .rstAll(rstAll), .busValue(busValue), .busToAc(busToAc),
        .acToBus(acToBus), .decAddAdjust(decAddAdjust), .decSubAdjust(decSubAdjust),
        .result(aluResult.consumer), .acReq(busReq[srcAccum]),
        .acData(slotData[srcAccum])
    );

    indexRegs u_indexRegs (
        .phi2(phi2), .rstAll(rstAll), .busValue(busValue), .busToX(busToX),
        .busToY(busToY), .busToSp(busToSp), .xToBus(xToBus), .yToBus(yToBus),
        .spToBus(spToBus), .req(indexReq), .xData(xData), .yData(yData), .spData(spData)
    );

    statusRegister u_statusRegister (
        .phi2(phi2), .rstAll(rstAll), .busValue(busValue), .busToP(busToP),
        .pToBus(pToBus), .flagsAluNzcv(flagsAluNzcv), .flagsAluNz(flagsAluNz),
        .loadNzFromBus(loadNzFromBus), .setC(setC), .clrC(clrC), .setI(setI),
        .clrI(clrI), .clrV(clrV), .setD(setD), .clrD(clrD),
        .result(aluResult.consumer), .pReq(busReq[srcStatus]),
        .pData(slotData[srcStatus]), .status(statusValue)
    );

    // request and data slots follow the busSource numbering
    assign slotData[srcDataLatch] = dlValue;
    assign busReq[srcX]           = indexReq[0];
    assign busReq[srcY]           = indexReq[1];
    assign busReq[srcStack]       = indexReq[2];
    assign slotData[srcX]         = xData;
    assign slotData[srcY]         = yData;
    assign slotData[srcStack]     = spData;

    busArbiter u_busArbiter (
        .sourceReq(busReq), .sourceData(slotData), .busValue(busValue)
    );

    assign status = statusValue.byteVal;

endmodule

`default_nettype wire

// ==== rtl/indexRegs.sv ====
// index and stack registers
//   X, Y and stack pointer as one small register bank
//   per register load strobe from the bus and bus request
`timescale 1ns/10ps
`default_nettype none

module indexRegs import datapathPkg::*; (
    input  logic       phi2,
    input  logic       rstAll,
    input  dataWord    busValue,
    input  logic       busToX,
    input  logic       busToY,
    input  logic       busToSp,
    input  logic       xToBus,
    input  logic       yToBus,
    input  logic       spToBus,
    output logic [2:0] req,
    output dataWord    xData,
    output dataWord    yData,
    output dataWord    spData
);

    // slot 0 is X, 1 is Y, 2 is the stack pointer
    logic [2:0] loadSel;
    dataWord    bank [3];

    assign loadSel = {busToSp, busToY, busToX};

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            for (int r = 0; r < 3; r++) begin
                bank[r] <= '0;
            end
        end else begin
            for (int r = 0; r < 3; r++) begin
                if (loadSel[r]) begin
                    bank[r] <= busValue;
                end
            end
        end
    end

    assign req    = {spToBus, yToBus, xToBus};
    assign xData  = bank[0];
    assign yData  = bank[1];
    assign spData = bank[2];

endmodule

`default_nettype wire

// ==== rtl/statusPkg.sv ====
// processor status word definitions
//   status word as a raw byte or as named flags
//   fixed levels of the unused bit and the break bit
//   status value after reset
`default_nettype none

package statusPkg;

    import datapathPkg::*;

    // NV-BDIZC from bit 7 down to bit 0
    typedef union packed {
        dataWord byteVal;
        struct packed {
            logic n;
            logic v;
            logic one;
            logic brk;
            logic d;
            logic i;
            logic z;
            logic c;
        } flags;
    } statusWord;

    // bit 5 always reads back high, bit 4 only exists on the stack
    localparam logic unusedBitLevel = 1'b1;
    localparam logic brkBitLevel    = 1'b0;

    localparam dataWord statusResetValue = 8'h20;

endpackage

`default_nettype wire

// ==== rtl/statusRegister.sv ====
// processor status register
//   flag updates from the ALU hold flags, from the bus, and from strobes
//   fixed update priority, one source per cycle
//   readback onto the bus and the status output
`timescale 1ns/10ps
`default_nettype none

module statusRegister
    import datapathPkg::*;
    import statusPkg::*;
(
    input  logic      phi2,
    input  logic      rstAll,
    input  dataWord   busValue,
    input  logic      busToP,
    input  logic      pToBus,
    input  logic      flagsAluNzcv,
    input  logic      flagsAluNz,
    input  logic      loadNzFromBus,
    input  logic      setC,
    input  logic      clrC,
    input  logic      setI,
    input  logic      clrI,
    input  logic      clrV,
    input  logic      setD,
    input  logic      clrD,
    aluResultIf.consumer result,
    output logic      pReq,
    output dataWord   pData,
    output statusWord status
);

    statusWord pReg;
    statusWord busStatus;

    // a full load keeps bits 5 and 4 at their fixed levels
    always_comb begin
        busStatus.byteVal   = busValue;
        busStatus.flags.one = unusedBitLevel;
        busStatus.flags.brk = brkBitLevel;
    end

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            pReg.byteVal <= statusResetValue;
        end else if (flagsAluNzcv) begin
            pReg.flags.n <= result.holdValue[7];
            pReg.flags.z <= (result.holdValue == '0);
            pReg.flags.c <= result.carry;
            pReg.flags.v <= result.overflow;
        end else if (flagsAluNz) begin
            pReg.flags.n <= result.holdValue[7];
            pReg.flags.z <= (result.holdValue == '0);
        end else if (loadNzFromBus) begin
            pReg.flags.n <= busValue[7];
            pReg.flags.z <= (busValue == '0);
        end else if (busToP) begin
            pReg <= busStatus;
        end else begin
            // set beats clear when both arrive together
            pReg.flags.c <= setC | (~clrC & pReg.flags.c);
            pReg.flags.i <= setI | (~clrI & pReg.flags.i);
            pReg.flags.d <= setD | (~clrD & pReg.flags.d);
            pReg.flags.v <= ~clrV & pReg.flags.v;
        end
    end

    assign pReq   = pToBus;
    assign pData  = pReg.byteVal;
    assign status = pReg;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the datapath testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv --top-module datapathBench \
    --Mdir obj_dir -o datapathSim -f sources.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/datapathSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "All checks passed" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

// ==== sources.f ====
rtl/datapathPkg.sv
rtl/statusPkg.sv
rtl/aluResultIf.sv
rtl/busArbiter.sv
rtl/aluCore.sv
rtl/accumulator.sv
rtl/indexRegs.sv
rtl/statusRegister.sv
rtl/dataPort.sv
rtl/datapathTop.sv
bench/datapathBench.sv
